/* cmd_pkg.sv */
`default_nettype none

package cmd_pkg;

	// width of the run length field
	parameter int COUNT_W = 8;

	// 2'd3 is not assigned and is rejected like OP_RESERVED
	typedef enum logic [1:0] {
		OP_ROUTE    = 2'd0,
		OP_DISCARD  = 2'd1,
		OP_RESERVED = 2'd2
	} route_op_e;

	typedef enum logic {
		SRC_PACKED = 1'b0,
		SRC_WIDE   = 1'b1
	} route_src_e;

	typedef enum logic {
		DST_C = 1'b0,
		DST_D = 1'b1
	} route_dst_e;

	// run length is count+1 words
	typedef struct packed {
		route_op_e            op;
		route_src_e           src;
		route_dst_e           dst;
		logic [COUNT_W-1:0]   count;
	} route_cmd_t;

endpackage

`default_nettype wire

/* lane_pkg.sv */
`default_nettype none

package lane_pkg;

	parameter int NUM_PORTS = 2;
	parameter int NUM_SRCS  = 2;

	// one-hot bit positions
	parameter int SEL_PACKED = 0;
	parameter int SEL_WIDE   = 1;
	parameter int PORT_C     = 0;
	parameter int PORT_D     = 1;

	typedef enum logic {
		LANE_IDLE = 1'b0,
		LANE_BUSY = 1'b1
	} lane_state_e;

	typedef struct packed {
		logic [NUM_SRCS-1:0]          src_sel;
		logic [NUM_PORTS-1:0]         dst_sel;
		logic                         discard;
		logic [cmd_pkg::COUNT_W-1:0]  total;
	} lane_ctrl_t;

endpackage

`default_nettype wire

/* beat_packer.sv */
`timescale 1ns/1ps
`default_nettype none

module beat_packer #(
	parameter int NARROW_W = 16,
	parameter int RATIO    = 6,
	parameter int WORD_W   = NARROW_W * RATIO
) (
	input  wire                 clk,
	input  wire                 rst_n,
	input  wire [NARROW_W-1:0]  narrow_data,
	input  wire                 narrow_last,
	input  wire                 narrow_valid,
	output logic                narrow_ready,
	output logic [WORD_W-1:0]   word_data,
	output logic                word_valid,
	input  wire                 word_ready
);

	localparam int CNT_W = (RATIO > 1) ? $clog2(RATIO) : 1;

	logic [CNT_W-1:0]   cnt;
	logic [WORD_W-1:0]  stage;
	logic [WORD_W-1:0]  stage_next;
	logic [WORD_W-1:0]  packed_word;
	logic               take;
	logic               flush;

	// stall only while the output word is stuck
	assign narrow_ready = !word_valid || word_ready;
	assign take = narrow_valid && narrow_ready;
	assign flush = take && (narrow_last || cnt == CNT_W'(RATIO - 1));

	always_comb begin
		stage_next = stage;
		stage_next[cnt*NARROW_W +: NARROW_W] = narrow_data;
	end

	// slices above the current beat were never written in this frame
	always_comb begin
		for (int i = 0; i < RATIO; i++) begin
			if (i <= int'(cnt))
				packed_word[i*NARROW_W +: NARROW_W] = stage_next[i*NARROW_W +: NARROW_W];
			else
				packed_word[i*NARROW_W +: NARROW_W] = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_n) begin
			cnt <= '0;
			word_valid <= 1'b0;
		end else begin
			if (take)
				cnt <= flush ? '0 : cnt + 1'b1;
			if (flush)
				word_valid <= 1'b1;
			else if (word_ready)
				word_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			stage <= stage_next;
		if (flush)
			word_data <= packed_word;
	end

endmodule

`default_nettype wire

/* route_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module route_decode (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire cmd_pkg::route_cmd_t    cmd,
	input  wire                         cmd_valid,
	output logic                        cmd_ready,
	output lane_pkg::lane_ctrl_t        ctrl,
	output logic                        ctrl_valid,
	input  wire                         lane_idle,
	output logic                        cmd_error
);

	lane_pkg::lane_ctrl_t  dec;
	logic                  accept;
	logic                  legal;
	logic                  launched;

	assign cmd_ready = lane_idle && !ctrl_valid;
	assign accept = cmd_valid && cmd_ready;
	assign legal = (cmd.op == cmd_pkg::OP_ROUTE) || (cmd.op == cmd_pkg::OP_DISCARD);

	always_comb begin
		dec = '0;
		dec.src_sel[lane_pkg::SEL_PACKED] = (cmd.src == cmd_pkg::SRC_PACKED);
		dec.src_sel[lane_pkg::SEL_WIDE] = (cmd.src == cmd_pkg::SRC_WIDE);
		// discard has no destination
		if (cmd.op == cmd_pkg::OP_ROUTE) begin
			dec.dst_sel[lane_pkg::PORT_C] = (cmd.dst == cmd_pkg::DST_C);
			dec.dst_sel[lane_pkg::PORT_D] = (cmd.dst == cmd_pkg::DST_D);
		end
		dec.discard = (cmd.op == cmd_pkg::OP_DISCARD);
		dec.total = cmd.count;
	end

	// launched marks that the lane has left idle for this command
	always_ff @(posedge clk) begin
		if (rst_n) begin
			ctrl_valid <= 1'b0;
			launched <= 1'b0;
			cmd_error <= 1'b0;
		end else begin
			cmd_error <= accept && !legal;
			if (accept && legal)
				ctrl_valid <= 1'b1;
			else if (launched && lane_idle)
				ctrl_valid <= 1'b0;
			if (ctrl_valid && !lane_idle)
				launched <= 1'b1;
			else if (launched && lane_idle)
				launched <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			ctrl <= dec;
	end

endmodule

`default_nettype wire

/* lane_switch.sv */
`timescale 1ns/1ps
`default_nettype none

module lane_switch #(
	parameter int WORD_W = 96
) (
	input  wire                              clk,
	input  wire                              rst_n,
	input  wire lane_pkg::lane_ctrl_t        ctrl,
	input  wire                              ctrl_valid,
	output logic                             lane_idle,
	input  wire [WORD_W-1:0]                 packed_data,
	input  wire                              packed_valid,
	output logic                             packed_ready,
	input  wire [WORD_W-1:0]                 wide_data,
	input  wire                              wide_valid,
	output logic                             wide_ready,
	output logic [WORD_W-1:0]                word_data,
	output logic                             word_last,
	output logic [lane_pkg::NUM_PORTS-1:0]   port_valid,
	input  wire [lane_pkg::NUM_PORTS-1:0]    port_ready,
	output logic                             done
);

	lane_pkg::lane_state_e          state;
	logic [cmd_pkg::COUNT_W-1:0]    cnt;
	logic                           busy;
	logic                           src_valid;
	logic                           sink_ready;
	logic                           xfer;

	assign busy = (state == lane_pkg::LANE_BUSY);
	assign lane_idle = (state == lane_pkg::LANE_IDLE);

	assign src_valid = |(ctrl.src_sel & {wide_valid, packed_valid});
	assign word_data = ctrl.src_sel[lane_pkg::SEL_WIDE] ? wide_data : packed_data;
	assign word_last = (cnt == ctrl.total);

	// discard sinks every word
	assign sink_ready = ctrl.discard || |(ctrl.dst_sel & port_ready);
	assign port_valid = busy ? (ctrl.dst_sel & {lane_pkg::NUM_PORTS{src_valid}}) : '0;
	assign packed_ready = busy && ctrl.src_sel[lane_pkg::SEL_PACKED] && sink_ready;
	assign wide_ready = busy && ctrl.src_sel[lane_pkg::SEL_WIDE] && sink_ready;
	assign xfer = busy && src_valid && sink_ready;

	always_ff @(posedge clk) begin
		if (rst_n) begin
			state <= lane_pkg::LANE_IDLE;
			cnt <= '0;
			done <= 1'b0;
		end else begin
			done <= xfer && word_last;
			case (state)
				lane_pkg::LANE_IDLE: begin
					// done still high means ctrl is the finished run
					if (ctrl_valid && !done) begin
						state <= lane_pkg::LANE_BUSY;
						cnt <= '0;
					end
				end
				default: begin
					if (xfer) begin
						cnt <= cnt + 1'b1;
						if (word_last)
							state <= lane_pkg::LANE_IDLE;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* port_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module port_merge #(
	parameter int WORD_W = 96
) (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire [1:0][WORD_W-1:0]   lane_data,
	input  wire [1:0]               lane_last,
	input  wire [1:0]               lane_valid,
	output logic [1:0]              lane_ready,
	output logic [WORD_W-1:0]       out_data,
	output logic                    out_last,
	output logic                    out_valid,
	input  wire                     out_ready
);

	logic [1:0]  grant;
	logic        prio;
	logic        locked;
	logic        load_ok;
	logic        sel;
	logic        take;

	// locked while a run is partly through, so only prio may send
	always_comb begin
		grant = 2'b00;
		if (locked)
			grant[prio] = lane_valid[prio];
		else if (lane_valid[prio])
			grant[prio] = 1'b1;
		else
			grant[~prio] = lane_valid[~prio];
	end

	assign load_ok = !out_valid || out_ready;
	assign lane_ready = grant & {2{load_ok}};
	assign sel = grant[1];
	assign take = |grant && load_ok;

	always_ff @(posedge clk) begin
		if (rst_n) begin
			out_valid <= 1'b0;
			locked <= 1'b0;
			prio <= 1'b0;
		end else begin
			if (take)
				out_valid <= 1'b1;
			else if (out_ready)
				out_valid <= 1'b0;
			if (take) begin
				locked <= !lane_last[sel];
				// hand over after the end of a run
				prio <= lane_last[sel] ? ~sel : sel;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			out_data <= lane_data[sel];
			out_last <= lane_last[sel];
		end
	end

endmodule

`default_nettype wire

/* data_router.sv */
`timescale 1ns/1ps
`default_nettype none

module data_router #(
	parameter int NARROW_W = 16,
	parameter int RATIO    = 6,
	localparam int WORD_W  = NARROW_W * RATIO
) (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire [NARROW_W-1:0]          narrow_data,
	input  wire                         narrow_last,
	input  wire                         narrow_valid,
	output logic                        narrow_ready,
	input  wire [WORD_W-1:0]            wide_data,
	input  wire                         wide_valid,
	output logic                        wide_ready,
	input  wire cmd_pkg::route_cmd_t    cmd_0,
	input  wire                         cmd_0_valid,
	output logic                        cmd_0_ready,
	input  wire cmd_pkg::route_cmd_t    cmd_1,
	input  wire                         cmd_1_valid,
	output logic                        cmd_1_ready,
	output logic [WORD_W-1:0]           out_c_data,
	output logic                        out_c_last,
	output logic                        out_c_valid,
	input  wire                         out_c_ready,
	output logic [WORD_W-1:0]           out_d_data,
	output logic                        out_d_last,
	output logic                        out_d_valid,
	input  wire                         out_d_ready,
	output logic [1:0]                  done,
	output logic [1:0]                  cmd_error
);

	localparam int NP = lane_pkg::NUM_PORTS;

	cmd_pkg::route_cmd_t [1:0]    cmd;
	logic [1:0]                   cmd_valid;
	logic [1:0]                   cmd_ready;
	lane_pkg::lane_ctrl_t [1:0]   ctrl;
	logic [1:0]                   ctrl_valid;
	logic [1:0]                   lane_idle;
	logic [1:0]                   lane_packed_ready;
	logic [1:0]                   lane_wide_ready;
	logic [1:0][WORD_W-1:0]       word_data;
	logic [1:0]                   word_last;
	logic [1:0][NP-1:0]           port_valid;
	logic [1:0][NP-1:0]           port_ready;
	logic [NP-1:0][1:0]           merge_valid;
	logic [NP-1:0][1:0]           merge_ready;
	logic [NP-1:0][WORD_W-1:0]    out_data;
	logic [NP-1:0]                out_last;
	logic [NP-1:0]                out_valid;
	logic [NP-1:0]                out_ready;
	logic [WORD_W-1:0]            packed_data;
	logic                         packed_valid;

	assign cmd = {cmd_1, cmd_0};
	assign cmd_valid = {cmd_1_valid, cmd_0_valid};
	assign cmd_0_ready = cmd_ready[0];
	assign cmd_1_ready = cmd_ready[1];

	// software keeps two lanes off the same source
	assign wide_ready = |lane_wide_ready;

	beat_packer #(.NARROW_W(NARROW_W), .RATIO(RATIO), .WORD_W(WORD_W)) u_packer (
		.clk(clk), .rst_n(rst_n),
		.narrow_data(narrow_data), .narrow_last(narrow_last),
		.narrow_valid(narrow_valid), .narrow_ready(narrow_ready),
		.word_data(packed_data), .word_valid(packed_valid),
		.word_ready(|lane_packed_ready)
	);

	for (genvar l = 0; l < 2; l++) begin : g_lane
		route_decode u_decode (
			.clk(clk), .rst_n(rst_n),
			.cmd(cmd[l]), .cmd_valid(cmd_valid[l]), .cmd_ready(cmd_ready[l]),
			.ctrl(ctrl[l]), .ctrl_valid(ctrl_valid[l]),
			.lane_idle(lane_idle[l]), .cmd_error(cmd_error[l])
		);

		lane_switch #(.WORD_W(WORD_W)) u_switch (
			.clk(clk), .rst_n(rst_n),
			.ctrl(ctrl[l]), .ctrl_valid(ctrl_valid[l]), .lane_idle(lane_idle[l]),
			.packed_data(packed_data), .packed_valid(packed_valid),
			.packed_ready(lane_packed_ready[l]),
			.wide_data(wide_data), .wide_valid(wide_valid),
			.wide_ready(lane_wide_ready[l]),
			.word_data(word_data[l]), .word_last(word_last[l]),
			.port_valid(port_valid[l]), .port_ready(port_ready[l]),
			.done(done[l])
		);

		for (genvar p = 0; p < NP; p++) begin : g_cross
			assign merge_valid[p][l] = port_valid[l][p];
			assign port_ready[l][p] = merge_ready[p][l];
		end
	end

	for (genvar p = 0; p < NP; p++) begin : g_port
		port_merge #(.WORD_W(WORD_W)) u_merge (
			.clk(clk), .rst_n(rst_n),
			.lane_data(word_data), .lane_last(word_last),
			.lane_valid(merge_valid[p]), .lane_ready(merge_ready[p]),
			.out_data(out_data[p]), .out_last(out_last[p]),
			.out_valid(out_valid[p]), .out_ready(out_ready[p])
		);
	end

	assign out_ready[lane_pkg::PORT_C] = out_c_ready;
	assign out_ready[lane_pkg::PORT_D] = out_d_ready;
	assign out_c_data = out_data[lane_pkg::PORT_C];
	assign out_c_last = out_last[lane_pkg::PORT_C];
	assign out_c_valid = out_valid[lane_pkg::PORT_C];
	assign out_d_data = out_data[lane_pkg::PORT_D];
	assign out_d_last = out_last[lane_pkg::PORT_D];
	assign out_d_valid = out_valid[lane_pkg::PORT_D];

endmodule

`default_nettype wire

/* tb_data_router.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_data_router;

	localparam int NW = 16;
	localparam int RATIO = 6;
	localparam int W = NW * RATIO;
	localparam int TIMEOUT = 2000;

	localparam int EV_DONE_0 = 0;
	localparam int EV_DONE_1 = 1;
	localparam int EV_ERR_0 = 2;
	localparam int EV_OUT_C = 4;
	localparam int EV_OUT_D = 5;

	logic                 clk;
	logic                 rst_n;
	logic [NW-1:0]        narrow_data;
	logic                 narrow_last;
	logic                 narrow_valid;
	logic                 narrow_ready;
	logic [W-1:0]         wide_data;
	logic                 wide_valid;
	logic                 wide_ready;
	cmd_pkg::route_cmd_t  cmd_0;
	logic                 cmd_0_valid;
	logic                 cmd_0_ready;
	cmd_pkg::route_cmd_t  cmd_1;
	logic                 cmd_1_valid;
	logic                 cmd_1_ready;
	logic [W-1:0]         out_c_data;
	logic                 out_c_last;
	logic                 out_c_valid;
	logic                 out_c_ready = 1'b1;
	logic [W-1:0]         out_d_data;
	logic                 out_d_last;
	logic                 out_d_valid;
	logic                 out_d_ready = 1'b1;
	logic [1:0]           done;
	logic [1:0]           cmd_error;

	logic                 bp_c;
	logic                 bp_d;
	logic [31:0]          data_rng = 32'h9aef;
	logic [31:0]          ready_rng = 32'h9aef;
	logic [NW-1:0]        beats [12];
	logic [W-1:0]         wides [8];
	logic [W:0]           exp_q [$];
	logic [W:0]           got_c [$];
	logic [W:0]           got_d [$];
	int                   done_cnt [2];
	int                   err_cnt [2];
	int                   valid_cycles = 0;
	int                   wide_taken = 0;
	int                   checks = 0;
	int                   errors = 0;
	int                   timeouts = 0;

	data_router #(.NARROW_W(NW), .RATIO(RATIO)) UUT (
		.clk(clk), .rst_n(rst_n),
		.narrow_data(narrow_data), .narrow_last(narrow_last),
		.narrow_valid(narrow_valid), .narrow_ready(narrow_ready),
		.wide_data(wide_data), .wide_valid(wide_valid), .wide_ready(wide_ready),
		.cmd_0(cmd_0), .cmd_0_valid(cmd_0_valid), .cmd_0_ready(cmd_0_ready),
		.cmd_1(cmd_1), .cmd_1_valid(cmd_1_valid), .cmd_1_ready(cmd_1_ready),
		.out_c_data(out_c_data), .out_c_last(out_c_last),
		.out_c_valid(out_c_valid), .out_c_ready(out_c_ready),
		.out_d_data(out_d_data), .out_d_last(out_d_last),
		.out_d_valid(out_d_valid), .out_d_ready(out_d_ready),
		.done(done), .cmd_error(cmd_error)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// output ready, random only on the port under back-pressure
	always @(posedge clk) begin
		if (bp_c || bp_d)
			ready_rng <= lfsr_next(ready_rng);
		out_c_ready <= bp_c ? ready_rng[0] : 1'b1;
		out_d_ready <= bp_d ? ready_rng[0] : 1'b1;
	end

	// rst_n high holds the design in reset
	always @(posedge clk) begin
		if (!rst_n) begin
			if (out_c_valid && out_c_ready)
				got_c.push_back({out_c_last, out_c_data});
			if (out_d_valid && out_d_ready)
				got_d.push_back({out_d_last, out_d_data});
			if (out_c_valid || out_d_valid)
				valid_cycles++;
			if (wide_valid && wide_ready)
				wide_taken++;
			for (int l = 0; l < 2; l++) begin
				if (done[l])
					done_cnt[l]++;
				if (cmd_error[l])
					err_cnt[l]++;
			end
		end
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [W-1:0] rand_bits(input int n);
		logic [W-1:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r[i] = data_rng[0];
			data_rng = lfsr_next(data_rng);
		end
		return r;
	endfunction

	function automatic int event_count(input int which);
		case (which)
			EV_DONE_0: return done_cnt[0];
			EV_DONE_1: return done_cnt[1];
			EV_ERR_0: return err_cnt[0];
			EV_OUT_C: return got_c.size();
			EV_OUT_D: return got_d.size();
			default: return err_cnt[1];
		endcase
	endfunction

	// first beat lands in the low slice, slices past n stay zero
	function automatic logic [W:0] packed_word(input int first, input int n, input logic last);
		logic [W:0] w;
		w = '0;
		for (int i = 0; i < n; i++)
			w[i*NW +: NW] = beats[first + i];
		w[W] = last;
		return w;
	endfunction

	function automatic cmd_pkg::route_cmd_t make_cmd(input cmd_pkg::route_op_e op,
			input cmd_pkg::route_src_e src, input cmd_pkg::route_dst_e dst, input int count);
		cmd_pkg::route_cmd_t c;
		c.op = op;
		c.src = src;
		c.dst = dst;
		c.count = cmd_pkg::COUNT_W'(count);
		return c;
	endfunction

	task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
		checks++;
		if (got !== exp) begin
			$display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout while waiting for %s", what);
		timeouts++;
	endtask

	task automatic wait_event(input int which, input int target, input string what);
		int t;
		t = 0;
		while (event_count(which) < target && t < TIMEOUT) begin
			@(posedge clk);
			t++;
		end
		if (event_count(which) < target)
			report_timeout(what);
	endtask

	task automatic send_cmd(input int lane, input cmd_pkg::route_cmd_t c);
		int t;
		logic ok;
		if (lane == 0) begin
			cmd_0 <= c;
			cmd_0_valid <= 1'b1;
		end else begin
			cmd_1 <= c;
			cmd_1_valid <= 1'b1;
		end
		t = 0;
		ok = 1'b0;
		while (!ok && t < TIMEOUT) begin
			@(posedge clk);
			ok = (lane == 0) ? cmd_0_ready : cmd_1_ready;
			t++;
		end
		if (lane == 0)
			cmd_0_valid <= 1'b0;
		else
			cmd_1_valid <= 1'b0;
		if (!ok)
			report_timeout("command accept");
	endtask

	task automatic push_beats(input int n);
		int t;
		for (int i = 0; i < n; i++) begin
			narrow_data <= beats[i];
			narrow_last <= (i == n - 1);
			narrow_valid <= 1'b1;
			t = 0;
			do begin
				@(posedge clk);
				t++;
			end while (!narrow_ready && t < TIMEOUT);
			if (!narrow_ready) begin
				report_timeout("narrow beat accept");
				break;
			end
		end
		narrow_valid <= 1'b0;
		narrow_last <= 1'b0;
	endtask

	task automatic push_wides(input int n);
		int t;
		for (int i = 0; i < n; i++) begin
			wide_data <= wides[i];
			wide_valid <= 1'b1;
			t = 0;
			do begin
				@(posedge clk);
				t++;
			end while (!wide_ready && t < TIMEOUT);
			if (!wide_ready) begin
				report_timeout("wide word accept");
				break;
			end
		end
		wide_valid <= 1'b0;
	endtask

	task automatic make_beats(input int n);
		logic [W-1:0] r;
		for (int i = 0; i < n; i++) begin
			r = rand_bits(NW);
			beats[i] = r[NW-1:0];
		end
	endtask

	task automatic make_wides(input int n);
		for (int i = 0; i < n; i++)
			wides[i] = rand_bits(W);
	endtask

	task automatic expect_port(input int port, input string name);
		logic [W:0] w;
		logic [W:0] e;
		wait_event(port == 0 ? EV_OUT_C : EV_OUT_D, exp_q.size(), {name, " words"});
		while (exp_q.size() > 0) begin
			e = exp_q.pop_front();
			if (event_count(port == 0 ? EV_OUT_C : EV_OUT_D) == 0)
				break;
			if (port == 0)
				w = got_c.pop_front();
			else
				w = got_d.pop_front();
			check({name, "_data"}, 128'(w[W-1:0]), 128'(e[W-1:0]));
			check({name, "_last"}, 128'(w[W]), 128'(e[W]));
		end
		exp_q.delete();
	endtask

	task automatic test_reset_state;
		check("out_c_valid", 128'(out_c_valid), 128'(0));
		check("out_d_valid", 128'(out_d_valid), 128'(0));
		check("done", 128'(done), 128'(0));
		check("cmd_error", 128'(cmd_error), 128'(0));
		check("cmd_0_ready", 128'(cmd_0_ready), 128'(1));
		check("cmd_1_ready", 128'(cmd_1_ready), 128'(1));
	endtask

	task automatic test_packed_route;
		int base;
		repeat (2) @(posedge clk);
		base = done_cnt[0];
		make_beats(12);
		exp_q.push_back(packed_word(0, 6, 1'b0));
		exp_q.push_back(packed_word(6, 6, 1'b1));
		fork
			send_cmd(0, make_cmd(cmd_pkg::OP_ROUTE, cmd_pkg::SRC_PACKED, cmd_pkg::DST_C, 1));
			push_beats(12);
		join
		expect_port(0, "out_c");
		wait_event(EV_DONE_0, base + 1, "done on lane 0");
		repeat (3) @(posedge clk);
		check("done[0] pulses", 128'(done_cnt[0]), 128'(base + 1));
	endtask

	task automatic test_short_frame;
		int base;
		repeat (2) @(posedge clk);
		base = done_cnt[1];
		make_beats(3);
		exp_q.push_back(packed_word(0, 3, 1'b1));
		fork
			send_cmd(1, make_cmd(cmd_pkg::OP_ROUTE, cmd_pkg::SRC_PACKED, cmd_pkg::DST_D, 0));
			push_beats(3);
		join
		expect_port(1, "out_d");
		wait_event(EV_DONE_1, base + 1, "done on lane 1");
		repeat (3) @(posedge clk);
		check("done[1] pulses", 128'(done_cnt[1]), 128'(base + 1));
	endtask

	task automatic test_backpressure;
		int base;
		repeat (2) @(posedge clk);
		base = done_cnt[0];
		bp_d <= 1'b1;
		make_wides(8);
		for (int i = 0; i < 8; i++)
			exp_q.push_back({i == 7, wides[i]});
		fork
			send_cmd(0, make_cmd(cmd_pkg::OP_ROUTE, cmd_pkg::SRC_WIDE, cmd_pkg::DST_D, 7));
			push_wides(8);
		join
		expect_port(1, "out_d");
		wait_event(EV_DONE_0, base + 1, "done on lane 0");
		bp_d <= 1'b0;
		repeat (3) @(posedge clk);
		check("done[0] pulses", 128'(done_cnt[0]), 128'(base + 1));
	endtask

	task automatic test_merge;
		logic [W:0] exp_a [$];
		logic [W:0] exp_b [$];
		logic [W:0] w;
		logic [W:0] e;
		int run;
		int base0;
		int base1;
		repeat (2) @(posedge clk);
		base0 = done_cnt[0];
		base1 = done_cnt[1];
		bp_c <= 1'b1;
		make_beats(12);
		make_wides(3);
		exp_a.push_back(packed_word(0, 6, 1'b0));
		exp_a.push_back(packed_word(6, 6, 1'b1));
		for (int i = 0; i < 3; i++)
			exp_b.push_back({i == 2, wides[i]});
		fork
			send_cmd(0, make_cmd(cmd_pkg::OP_ROUTE, cmd_pkg::SRC_PACKED, cmd_pkg::DST_C, 1));
			send_cmd(1, make_cmd(cmd_pkg::OP_ROUTE, cmd_pkg::SRC_WIDE, cmd_pkg::DST_C, 2));
			push_beats(12);
			push_wides(3);
		join
		wait_event(EV_OUT_C, 5, "merged words on out_c");
		wait_event(EV_DONE_0, base0 + 1, "done on lane 0");
		wait_event(EV_DONE_1, base1 + 1, "done on lane 1");
		bp_c <= 1'b0;
		repeat (3) @(posedge clk);
		run = -1;
		while (got_c.size() > 0) begin
			w = got_c.pop_front();
			// a new run may come from either lane
			if (run < 0)
				run = (exp_a.size() > 0 && w == exp_a[0]) ? 0 : 1;
			if (run == 0 && exp_a.size() > 0) begin
				e = exp_a.pop_front();
			end else if (run == 1 && exp_b.size() > 0) begin
				e = exp_b.pop_front();
			end else begin
				$display("out_c delivered a word that belongs to no open run");
				errors++;
				break;
			end
			check("out_c merged word", 128'(w), 128'(e));
			if (w[W])
				run = -1;
		end
		check("packed words missing", 128'(exp_a.size()), 128'(0));
		check("wide words missing", 128'(exp_b.size()), 128'(0));
		check("done[0] pulses", 128'(done_cnt[0]), 128'(base0 + 1));
		check("done[1] pulses", 128'(done_cnt[1]), 128'(base1 + 1));
	endtask

	task automatic test_discard;
		int base_done;
		int base_valid;
		repeat (2) @(posedge clk);
		base_done = done_cnt[1];
		base_valid = valid_cycles;
		make_wides(4);
		fork
			send_cmd(1, make_cmd(cmd_pkg::OP_DISCARD, cmd_pkg::SRC_WIDE, cmd_pkg::DST_C, 3));
			push_wides(4);
		join
		wait_event(EV_DONE_1, base_done + 1, "done on discard");
		repeat (3) @(posedge clk);
		check("done[1] pulses", 128'(done_cnt[1]), 128'(base_done + 1));
		check("output valid cycles", 128'(valid_cycles), 128'(base_valid));
	endtask

	task automatic test_illegal_opcode;
		cmd_pkg::route_op_e bad [2];
		int base_err;
		int base_done;
		int base_valid;
		int base_taken;
		bad[0] = cmd_pkg::OP_RESERVED;
		bad[1] = cmd_pkg::route_op_e'(2'd3);
		// a wide word stays offered while the bad commands go in
		make_wides(1);
		wide_data <= wides[0];
		wide_valid <= 1'b1;
		for (int k = 0; k < 2; k++) begin
			repeat (2) @(posedge clk);
			base_err = err_cnt[0];
			base_done = done_cnt[0];
			base_valid = valid_cycles;
			base_taken = wide_taken;
			send_cmd(0, make_cmd(bad[k], cmd_pkg::SRC_WIDE, cmd_pkg::DST_C, 2));
			wait_event(EV_ERR_0, base_err + 1, "cmd_error on lane 0");
			repeat (3) @(posedge clk);
			check("cmd_error[0] pulses", 128'(err_cnt[0]), 128'(base_err + 1));
			check("cmd_0_ready", 128'(cmd_0_ready), 128'(1));
			check("wide words taken", 128'(wide_taken), 128'(base_taken));
			check("done[0] pulses", 128'(done_cnt[0]), 128'(base_done));
			check("output valid cycles", 128'(valid_cycles), 128'(base_valid));
		end
		// the offered word is drained by a legal discard
		base_done = done_cnt[0];
		fork
			send_cmd(0, make_cmd(cmd_pkg::OP_DISCARD, cmd_pkg::SRC_WIDE, cmd_pkg::DST_C, 0));
			push_wides(1);
		join
		wait_event(EV_DONE_0, base_done + 1, "done on lane 0");
	endtask

	initial begin
		rst_n <= 1'b1;
		narrow_data <= '0;
		narrow_last <= 1'b0;
		narrow_valid <= 1'b0;
		wide_data <= '0;
		wide_valid <= 1'b0;
		cmd_0 <= '0;
		cmd_0_valid <= 1'b0;
		cmd_1 <= '0;
		cmd_1_valid <= 1'b0;
		bp_c <= 1'b0;
		bp_d <= 1'b0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b0;
		@(posedge clk);
		test_reset_state();
		test_packed_route();
		test_short_frame();
		test_backpressure();
		test_merge();
		test_discard();
		test_illegal_opcode();
		repeat (4) @(posedge clk);
		check("stray words on out_c", 128'(got_c.size()), 128'(0));
		check("stray words on out_d", 128'(got_d.size()), 128'(0));
		$display("checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
cmd_pkg.sv
lane_pkg.sv
beat_packer.sv
route_decode.sv
lane_switch.sv
port_merge.sv
data_router.sv
tb_data_router.sv

/* Makefile */
.PHONY: compile run clean

compile:
	verilator --binary --timing --top-module tb_data_router -f compile.f -o tb_data_router

run: compile
	./obj_dir/tb_data_router | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
